//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_mul_unit
RTL_TOP    ?= mul_unit
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/mul_checker.sv
`default_nettype none
`include "mul_params.svh"

module mul_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mul_pkg::mul_op_t op,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic             out_valid,
    input  logic [`XLEN-1:0] result,
    output int               value_errors,
    output int               latency_errors,
    output int               protocol_errors,
    output int               pending
);

    // edges from in_valid sample to out_valid sample
    localparam int LATENCY = 3;

    // scoreboard, one entry per issued op, oldest first
    logic [`XLEN-1:0] exp_q [$];
    int               cyc_q [$];
    int               seq_q [$];
    mul_pkg::mul_op_t op_q [$];

    int cycle_no = 0;
    int seq_no = 0;
    int value_errs = 0;
    int latency_errs = 0;
    int protocol_errs = 0;
    int pending_cnt = 0;

    assign value_errors    = value_errs;
    assign latency_errors  = latency_errs;
    assign protocol_errors = protocol_errs;
    assign pending         = pending_cnt;

    // widen both operands by the opcode's signedness, keep the half it names
    function automatic logic [`XLEN-1:0] expected_result(input mul_pkg::mul_op_t o,
                                                         input logic [`XLEN-1:0] a,
                                                         input logic [`XLEN-1:0] b);
        logic [`PROD_W-1:0] wide_a;
        logic [`PROD_W-1:0] wide_b;
        logic [`PROD_W-1:0] prod;
        wide_a = {{`XLEN{(o != mul_pkg::MULHU) & a[`XLEN-1]}}, a};
        wide_b = {{`XLEN{(o == mul_pkg::MUL || o == mul_pkg::MULH) & b[`XLEN-1]}}, b};
        prod   = wide_a * wide_b;
        return (o == mul_pkg::MUL) ? prod[`XLEN-1:0] : prod[`PROD_W-1:`XLEN];
    endfunction

    function automatic string op_label(input mul_pkg::mul_op_t o);
        case (o)
            mul_pkg::MUL:    return "MUL";
            mul_pkg::MULH:   return "MULH";
            mul_pkg::MULHSU: return "MULHSU";
            default:         return "MULHU";
        endcase
    endfunction

    always @(posedge clk) begin
        logic [`XLEN-1:0] exp_val;
        int               issued_at;
        int               seq;
        mul_pkg::mul_op_t exp_op;
        cycle_no++;
        if (rst) begin
            // nothing may come out while the pipe is held in reset
            if (out_valid === 1'b1) begin
                protocol_errs++;
                $display("ERROR: out_valid went high during reset at cycle %0d", cycle_no);
            end
        end else begin
            if ($isunknown(out_valid)) begin
                protocol_errs++;
                $display("ERROR: out_valid is unknown after reset at cycle %0d", cycle_no);
            end else if (out_valid) begin
                if (exp_q.size() == 0) begin
                    protocol_errs++;
                    $display("ERROR: out_valid at cycle %0d with no operation pending",
                             cycle_no);
                end else begin
                    exp_val   = exp_q.pop_front();
                    issued_at = cyc_q.pop_front();
                    seq       = seq_q.pop_front();
                    exp_op    = op_q.pop_front();
                    if (result !== exp_val) begin
                        value_errs++;
                        $display("FAILED %s op %0d: expected %h, actual %h",
                                 op_label(exp_op), seq, exp_val, result);
                    end
                    // also catches a gap or reordering in a back-to-back run
                    if (cycle_no - issued_at != LATENCY) begin
                        latency_errs++;
                        $display("ERROR: %s op %0d came back after %0d cycles instead of %0d",
                                 op_label(exp_op), seq, cycle_no - issued_at, LATENCY);
                    end
                end
            end
            // expected value is taken when the unit samples the request
            if (in_valid) begin
                exp_q.push_back(expected_result(op, rs1_data, rs2_data));
                cyc_q.push_back(cycle_no);
                seq_q.push_back(seq_no);
                op_q.push_back(op);
                seq_no++;
            end
        end
        pending_cnt = exp_q.size();
    end

endmodule

`default_nettype wire

//--- bench/tb_mul_unit.sv
`default_nettype none
`include "mul_params.svh"

module tb_mul_unit;

    localparam int NUM_OPS = 2000;
    // at most four cycles per op with idle gaps plus reset and drain
    localparam int TIMEOUT_CYCLES = 4 * NUM_OPS + 100;

    logic             clk;
    logic             rst;
    logic             in_valid;
    mul_pkg::mul_op_t op;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             out_valid;
    logic [`XLEN-1:0] result;

    int value_errors;
    int latency_errors;
    int protocol_errors;
    int pending;
    int issued;
    int cycle_count;

    // zero, one, all-ones, most negative, most positive
    logic [`XLEN-1:0] corners [5];

    mul_unit UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (out_valid),
        .result    (result)
    );

    mul_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .op              (op),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .out_valid       (out_valid),
        .result          (result),
        .value_errors    (value_errors),
        .latency_errors  (latency_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // drives one op for one cycle and returns 1 unit past the next rising edge
    task automatic issue_op(input mul_pkg::mul_op_t o, input logic [`XLEN-1:0] a,
                            input logic [`XLEN-1:0] b);
        in_valid = 1'b1;
        op       = o;
        rs1_data = a;
        rs2_data = b;
        @(posedge clk);
        #1;
        issued++;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic report_counts();
        $display("errors: value %0d, latency %0d, protocol %0d, pending %0d",
                 value_errors, latency_errors, protocol_errors, pending);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        void'($urandom(26917));
        rst         = 1'b1;
        // ops offered while reset is held must never come out
        in_valid    = 1'b1;
        op          = mul_pkg::MULHU;
        rs1_data    = '1;
        rs2_data    = '1;
        issued      = 0;
        corners[0]  = '0;
        corners[1]  = 64'd1;
        corners[2]  = '1;
        corners[3]  = {1'b1, {(`XLEN-1){1'b0}}};
        corners[4]  = {1'b0, {(`XLEN-1){1'b1}}};
        repeat (5) @(posedge clk);
        #1;
        rst      = 1'b0;
        in_valid = 1'b0;
        // out_valid has to stay low in the quiet cycles after reset
        repeat (3) idle_cycle();
        // every corner pair for every opcode back to back
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(mul_pkg::mul_op_t'(k[1:0]), corners[i], corners[j]);
                end
            end
        end
        // random ops with about one idle cycle in four
        while (issued < NUM_OPS) begin
            rnd = $urandom;
            if (rnd[1:0] == 2'b00) begin
                idle_cycle();
            end
            issue_op(mul_pkg::mul_op_t'(rnd[3:2]), {$urandom, $urandom}, {$urandom, $urandom});
        end
        in_valid = 1'b0;
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        // any extra out_valid shows up in the trailing idle cycles
        repeat (4) idle_cycle();
        report_counts();
        if (value_errors + latency_errors + protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
verilog/mul_pkg.sv
verilog/mul_operand_stage.sv
verilog/booth2_decode.sv
verilog/csa_tree.sv
verilog/wallace_mul.sv
verilog/mul_result_stage.sv
verilog/mul_unit.sv
bench/mul_checker.sv
bench/tb_mul_unit.sv

//--- include/mul_params.svh
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// operand width of the integer core
`define XLEN 64
// full product width that is kept after the final add
`define PROD_W 128
// partial product width, wide enough for a 66 bit multiplier times a 65 bit multiplicand
`define EXT_W 132
// radix-4 booth rows, XLEN/2 plus one for the sign digit
`define PP_NUM 33

`endif

//--- verilog/booth2_decode.sv
`default_nettype none
`include "mul_params.svh"

module booth2_decode (
    input  logic [2:0]        booth2_code,
    input  logic [`EXT_W-1:0] x,
    output logic [`EXT_W-1:0] y,
    output logic              cin
);

    logic [`EXT_W-1:0] mag;
    logic              neg;

    // magnitude and sign of the digit {b[2i+1], b[2i], b[2i-1]}
    always_comb begin
        case (booth2_code)
            3'b001, 3'b010: begin
                mag = x;
                neg = 1'b0;
            end
            3'b011: begin
                mag = x << 1;
                neg = 1'b0;
            end
            3'b100: begin
                mag = x << 1;
                neg = 1'b1;
            end
            3'b101, 3'b110: begin
                mag = x;
                neg = 1'b1;
            end
            default: begin
                // 000 and 111 both give a zero row
                mag = '0;
                neg = 1'b0;
            end
        endcase
    end

    // negative rows are one's complement here
    // the +1 goes into the tree through cin
    assign y   = neg ? ~mag : mag;
    assign cin = neg;

endmodule

`default_nettype wire

//--- verilog/csa_tree.sv
`default_nettype none
`include "mul_params.svh"

module csa_tree (
    input  logic [`EXT_W-1:0]  pp [`PP_NUM],
    input  logic [`PP_NUM-1:0] pp_cin,
    output logic [`EXT_W-1:0]  sum_row,
    output logic [`EXT_W-1:0]  carry_row
);

    // 33 rows plus the carry-in row give 34 inputs
    // 34 -> 23 -> 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2
    localparam int LEVELS = 8;

    // row count entering a given level
    function automatic int rows_at(input int lvl);
        int n;
        n = `PP_NUM + 1;
        for (int k = 0; k < lvl; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    logic [`EXT_W-1:0] cin_row;

    // carry-in of row i sits at bit 2i, the lsb of that row after its shift
    always_comb begin
        cin_row = '0;
        for (int i = 0; i < `PP_NUM; i++) begin
            cin_row[2*i] = pp_cin[i];
        end
    end

    for (genvar l = 0; l <= LEVELS; l++) begin : lvl
        localparam int N = rows_at(l);

        logic [`EXT_W-1:0] r [N];

        if (l == 0) begin : init
            // align each booth row to its weight 4^i
            for (genvar i = 0; i < `PP_NUM; i++) begin : align
                assign r[i] = pp[i] << (2 * i);
            end
            assign r[`PP_NUM] = cin_row;
        end else begin : fold
            localparam int G   = rows_at(l - 1) / 3;
            localparam int REM = rows_at(l - 1) % 3;

            // one row of full adders per group of three
            for (genvar k = 0; k < G; k++) begin : csa
                logic [`EXT_W-1:0] a;
                logic [`EXT_W-1:0] b;
                logic [`EXT_W-1:0] c;

                assign a = lvl[l-1].r[3*k];
                assign b = lvl[l-1].r[3*k+1];
                assign c = lvl[l-1].r[3*k+2];

                // sum stays in place, majority moves up one bit
                assign r[2*k]   = a ^ b ^ c;
                assign r[2*k+1] = ((a & b) | (a & c) | (b & c)) << 1;
            end

            // leftover rows skip this level
            for (genvar m = 0; m < REM; m++) begin : pass
                assign r[2*G+m] = lvl[l-1].r[3*G+m];
            end
        end
    end

    assign sum_row   = lvl[LEVELS].r[0];
    assign carry_row = lvl[LEVELS].r[1];

endmodule

`default_nettype wire

//--- verilog/mul_operand_stage.sv
`default_nettype none
`include "mul_params.svh"

// request bundle from the input side to the multiplier array
interface mul_req_if;
    logic valid;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic op1_signed;
    logic op2_signed;
    logic high;

    modport src (
        output valid,
        output op1,
        output op2,
        output op1_signed,
        output op2_signed,
        output high
    );

    modport dst (
        input valid,
        input op1,
        input op2,
        input op1_signed,
        input op2_signed,
        input high
    );
endinterface

module mul_operand_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mul_pkg::mul_op_t op,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    mul_req_if.src           req
);

    logic dec_op1_signed;
    logic dec_op2_signed;
    logic dec_high;

    // opcode decode into sign handling and half select
    always_comb begin
        case (op)
            mul_pkg::MUL: begin
                dec_op1_signed = 1'b1;
                dec_op2_signed = 1'b1;
                dec_high       = 1'b0;
            end
            mul_pkg::MULH: begin
                dec_op1_signed = 1'b1;
                dec_op2_signed = 1'b1;
                dec_high       = 1'b1;
            end
            mul_pkg::MULHSU: begin
                dec_op1_signed = 1'b1;
                dec_op2_signed = 1'b0;
                dec_high       = 1'b1;
            end
            default: begin
                // MULHU, both unsigned
                dec_op1_signed = 1'b0;
                dec_op2_signed = 1'b0;
                dec_high       = 1'b1;
            end
        endcase
    end

    // valid strobe, one cycle per issued op
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= in_valid;
        end
    end

    // operands and flags only move when an op is issued
    always_ff @(posedge clk) begin
        if (in_valid) begin
            req.op1        <= rs1_data;
            req.op2        <= rs2_data;
            req.op1_signed <= dec_op1_signed;
            req.op2_signed <= dec_op2_signed;
            req.high       <= dec_high;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // multiply opcodes of the M extension
    // the encoding matches the low two bits of funct3 for OP with funct7 = 1
    typedef enum logic [1:0] {
        // signed x signed, low half
        MUL    = 2'b00,
        // signed x signed, high half
        MULH   = 2'b01,
        // signed rs1 x unsigned rs2, high half
        MULHSU = 2'b10,
        // unsigned x unsigned, high half
        MULHU  = 2'b11
    } mul_op_t;

endpackage

`default_nettype wire

//--- verilog/mul_result_stage.sv
`default_nettype none
`include "mul_params.svh"

module mul_result_stage (
    input  logic             clk,
    input  logic             rst,
    mul_res_if.dst           res,
    output logic             out_valid,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] half;

    // upper word for MULH*, lower word for MUL
    assign half = res.high ? res.product[`PROD_W-1:`XLEN] : res.product[`XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res.valid;
        end
    end

    // only the selected word reaches writeback
    always_ff @(posedge clk) begin
        if (res.valid) begin
            result <= half;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
`default_nettype none
`include "mul_params.svh"

module mul_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mul_pkg::mul_op_t op,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output logic             out_valid,
    output logic [`XLEN-1:0] result
);

    // stage 1 to stage 2
    mul_req_if req_bus ();
    // stage 2 to stage 3
    mul_res_if res_bus ();

    mul_operand_stage u_operand_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .op       (op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .req      (req_bus.src)
    );

    // booth array and wallace tree, product registered
    wallace_mul u_wallace_mul (
        .clk (clk),
        .rst (rst),
        .req (req_bus.dst),
        .res (res_bus.src)
    );

    mul_result_stage u_result_stage (
        .clk       (clk),
        .rst       (rst),
        .res       (res_bus.dst),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- verilog/wallace_mul.sv
`default_nettype none
`include "mul_params.svh"

// product bundle from the multiplier array to the output side
interface mul_res_if;
    logic valid;
    logic [`PROD_W-1:0] product;
    logic high;

    modport src (
        output valid,
        output product,
        output high
    );

    modport dst (
        input valid,
        input product,
        input high
    );
endinterface

module wallace_mul (
    input  logic    clk,
    input  logic    rst,
    mul_req_if.dst  req,
    mul_res_if.src  res
);

    logic              op2_ext;
    logic [`EXT_W-1:0] mul_op1;
    logic [2:0]        booth_code [`PP_NUM];
    logic [`EXT_W-1:0] pp [`PP_NUM];
    logic [`PP_NUM-1:0] pp_cin;
    logic [`EXT_W-1:0] sum_row;
    logic [`EXT_W-1:0] carry_row;
    logic [`PROD_W-1:0] full_sum;

    // multiplicand, sign or zero extended to the row width
    assign mul_op1 = {{(`EXT_W - `XLEN){req.op1_signed & req.op1[`XLEN-1]}}, req.op1};

    // bits 64 and 65 of the multiplier, zero for unsigned rs2
    assign op2_ext = req.op2_signed & req.op2[`XLEN-1];

    // overlapping 3 bit digits, an implicit zero below bit 0
    assign booth_code[0] = {req.op2[1:0], 1'b0};
    for (genvar i = 1; i < `PP_NUM - 1; i++) begin : code
        assign booth_code[i] = req.op2[2*i+1:2*i-1];
    end
    assign booth_code[`PP_NUM-1] = {op2_ext, op2_ext, req.op2[`XLEN-1]};

    for (genvar i = 0; i < `PP_NUM; i++) begin : dec
        booth2_decode u_booth2_decode (
            .booth2_code (booth_code[i]),
            .x           (mul_op1),
            .y           (pp[i]),
            .cin         (pp_cin[i])
        );
    end

    csa_tree u_csa_tree (
        .pp        (pp),
        .pp_cin    (pp_cin),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    // final carry-propagate add, only the kept bits matter
    assign full_sum = sum_row[`PROD_W-1:0] + carry_row[`PROD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req.valid;
        end
    end

    // product and half select ride along with the valid
    always_ff @(posedge clk) begin
        if (req.valid) begin
            res.product <= full_sum;
            res.high    <= req.high;
        end
    end

endmodule

`default_nettype wire
